//--- rtl/rhythm_pkg.sv
package rhythm_pkg;

    localparam int NOTE_COUNT = 12;
    localparam int MELODY_LEN = 16;

    typedef logic [3:0] note_t;
    typedef logic [2:0] dur_t;
    typedef logic [3:0] round_t;

    // Melody pitches as button indices
    localparam note_t MELODY_NOTES [MELODY_LEN] = '{
        4'd4, 4'd4, 4'd6, 4'd4,
        4'd9, 4'd8, 4'd4, 4'd4,
        4'd6, 4'd4, 4'd11, 4'd9,
        4'd4, 4'd4, 4'd1, 4'd11
    };

    // Durations in beat units and never zero
    localparam dur_t MELODY_DURS [MELODY_LEN] = '{
        3'd3, 3'd1, 3'd2, 3'd2,
        3'd2, 3'd4, 3'd1, 3'd1,
        3'd2, 3'd2, 3'd2, 3'd4,
        3'd1, 3'd1, 3'd2, 3'd4
    };

    // Button or LED pattern for a single note
    function automatic logic [NOTE_COUNT-1:0] note_onehot(input note_t n);
        logic [NOTE_COUNT-1:0] one;
        one = {{(NOTE_COUNT-1){1'b0}}, 1'b1};
        return one << n;
    endfunction

endpackage

//--- rtl/note_checker.sv
`timescale 1ns/1ps

module note_checker (
    input  logic                               clock,
    input  logic                               rst_n,
    input  logic                               listen,
    input  logic [rhythm_pkg::NOTE_COUNT-1:0]  buttons,
    input  rhythm_pkg::note_t                  exp_note,
    output logic                               press,
    output logic                               note_ok
);

    import rhythm_pkg::*;

    logic [NOTE_COUNT-1:0] sync_1;
    logic [NOTE_COUNT-1:0] sync_2;
    logic                  any_now;
    logic                  any_prev;

    // Two-stage synchronizer on the raw buttons
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            sync_1 <= '0;
            sync_2 <= '0;
        end else begin
            sync_1 <= buttons;
            sync_2 <= sync_1;
        end
    end

    assign any_now = |sync_2;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            any_prev <= 1'b0;
        end else begin
            any_prev <= any_now;
        end
    end

    // Edge from released to pressed counts only in the player's turn
    assign press = listen && any_now && !any_prev;

    // Exactly one button down and it is the expected one
    assign note_ok = (sync_2 == note_onehot(exp_note));

endmodule

//--- rtl/timing_checker.sv
`timescale 1ns/1ps

module timing_checker #(
    parameter int TICKS_PER_UNIT = 12500000
) (
    input  logic              clock,
    input  logic              rst_n,
    input  logic              restart,
    input  rhythm_pkg::dur_t  exp_dur,
    output logic              span_done,
    output logic              time_ok,
    output logic              time_out
);

    localparam int TW = (TICKS_PER_UNIT > 1) ? $clog2(TICKS_PER_UNIT) : 1;
    localparam logic [TW-1:0] TICK_LAST = TW'(TICKS_PER_UNIT - 1);

    logic [TW-1:0] tick_cnt;
    logic [3:0]    units;
    logic [3:0]    dur_ext;
    logic [3:0]    limit;
    logic [3:0]    units_next;
    logic          expired;
    logic          unit_end;

    assign dur_ext    = {1'b0, exp_dur};
    assign limit      = dur_ext + 4'd1;
    assign units_next = units + 4'd1;

    // Counter freezes once the window has been overrun
    assign expired  = (units == limit);
    assign unit_end = !expired && (tick_cnt == TICK_LAST);

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            tick_cnt <= '0;
            units    <= 4'd0;
        end else if (restart) begin
            tick_cnt <= '0;
            units    <= 4'd0;
        end else if (unit_end) begin
            tick_cnt <= '0;
            units    <= units_next;
        end else if (!expired) begin
            tick_cnt <= tick_cnt + 1'b1;
        end
    end

    // Pulses sit in the last cycle before the unit count changes,
    // so the controller acts on the exact boundary
    assign span_done = unit_end && (units_next == dur_ext);
    assign time_out  = unit_end && (units_next == limit);

    // Window spans the last unit of the note and the unit after it
    assign time_ok = (units == dur_ext - 4'd1) || (units == dur_ext);

endmodule

//--- rtl/game_control.sv
`timescale 1ns/1ps

module game_control #(
    parameter int NUM_ROUNDS = 16
) (
    input  logic                               clock,
    input  logic                               rst_n,
    input  logic                               start,
    input  logic                               press,
    input  logic                               note_ok,
    input  logic                               span_done,
    input  logic                               time_ok,
    input  logic                               time_out,
    output rhythm_pkg::note_t                  exp_note,
    output rhythm_pkg::dur_t                   exp_dur,
    output logic                               restart,
    output logic                               listen,
    output logic [rhythm_pkg::NOTE_COUNT-1:0]  leds,
    output logic                               player_turn,
    output logic                               won,
    output logic                               lost,
    output rhythm_pkg::round_t                 round
);

    import rhythm_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_play,
        st_turn,
        st_won,
        st_lost
    } state_t;

    localparam round_t LAST_ROUND = round_t'(NUM_ROUNDS - 1);

    state_t state;
    round_t addr;
    round_t round_q;
    logic   good_press;
    logic   at_round_end;

    assign good_press   = press && note_ok && time_ok;
    assign at_round_end = (addr == round_q);

    // Melody lookup at the current address
    assign exp_note = MELODY_NOTES[addr];
    assign exp_dur  = MELODY_DURS[addr];

    // Timer restarts on every note boundary and every accepted press
    always_comb begin
        restart = 1'b0;
        case (state)
            st_play: restart = span_done;
            st_turn: restart = good_press;
            default: restart = start;
        endcase
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state   <= st_idle;
            addr    <= '0;
            round_q <= '0;
        end else begin
            case (state)
                st_play: begin
                    if (span_done) begin
                        if (at_round_end) begin
                            state <= st_turn;
                            addr  <= '0;
                        end else begin
                            addr <= addr + 1'b1;
                        end
                    end
                end
                st_turn: begin
                    // Press wins over a timeout in the same cycle
                    if (press) begin
                        if (!good_press) begin
                            state <= st_lost;
                        end else if (!at_round_end) begin
                            addr <= addr + 1'b1;
                        end else if (round_q == LAST_ROUND) begin
                            state <= st_won;
                        end else begin
                            round_q <= round_q + 1'b1;
                            addr    <= '0;
                            state   <= st_play;
                        end
                    end else if (time_out) begin
                        state <= st_lost;
                    end
                end
                default: begin
                    if (start) begin
                        state   <= st_play;
                        addr    <= '0;
                        round_q <= '0;
                    end
                end
            endcase
        end
    end

    assign leds        = (state == st_play) ? note_onehot(exp_note) : '0;
    assign player_turn = (state == st_turn);
    assign listen      = (state == st_turn);
    assign won         = (state == st_won);
    assign lost        = (state == st_lost);
    assign round       = round_q;

endmodule

//--- rtl/rhythm_game.sv
`timescale 1ns/1ps

module rhythm_game #(
    parameter int TICKS_PER_UNIT = 12500000,  // 50 MHz clock
    parameter int NUM_ROUNDS     = 16
) (
    input  logic                               clock,
    input  logic                               rst_n,
    input  logic                               start,
    input  logic [rhythm_pkg::NOTE_COUNT-1:0]  buttons,
    output logic [rhythm_pkg::NOTE_COUNT-1:0]  leds,
    output logic                               player_turn,
    output logic                               won,
    output logic                               lost,
    output rhythm_pkg::round_t                 round
);

    import rhythm_pkg::*;

    note_t exp_note;
    dur_t  exp_dur;
    logic  restart;
    logic  listen;
    logic  press;
    logic  note_ok;
    logic  span_done;
    logic  time_ok;
    logic  time_out;

    // Note verdict
    note_checker note_checker_i (
        .clock    ( clock    ),
        .rst_n    ( rst_n    ),
        .listen   ( listen   ),
        .buttons  ( buttons  ),
        .exp_note ( exp_note ),
        .press    ( press    ),
        .note_ok  ( note_ok  )
    );

    // Timing verdict and playback pacing
    timing_checker #(.TICKS_PER_UNIT(TICKS_PER_UNIT)) timing_checker_i (
        .clock     ( clock     ),
        .rst_n     ( rst_n     ),
        .restart   ( restart   ),
        .exp_dur   ( exp_dur   ),
        .span_done ( span_done ),
        .time_ok   ( time_ok   ),
        .time_out  ( time_out  )
    );

    game_control #(.NUM_ROUNDS(NUM_ROUNDS)) game_control_i (
        .clock       ( clock       ),
        .rst_n       ( rst_n       ),
        .start       ( start       ),
        .press       ( press       ),
        .note_ok     ( note_ok     ),
        .span_done   ( span_done   ),
        .time_ok     ( time_ok     ),
        .time_out    ( time_out    ),
        .exp_note    ( exp_note    ),
        .exp_dur     ( exp_dur     ),
        .restart     ( restart     ),
        .listen      ( listen      ),
        .leds        ( leds        ),
        .player_turn ( player_turn ),
        .won         ( won         ),
        .lost        ( lost        ),
        .round       ( round       )
    );

endmodule

//--- testbench/rhythm_game_asserts.sv
`timescale 1ns/1ps

module rhythm_game_asserts (
    input logic                              clock,
    input logic                              rst_n,
    input logic                              start,
    input logic [rhythm_pkg::NOTE_COUNT-1:0] leds,
    input logic                              player_turn,
    input logic                              won,
    input logic                              lost
);

    leds_onehot: assert property (@(posedge clock) disable iff (!rst_n) $onehot0(leds))
        else $error("leds has more than one bit set");

    // LEDs stay dark while the player answers
    leds_dark_in_turn: assert property (@(posedge clock) disable iff (!rst_n)
        player_turn |-> leds == '0)
        else $error("leds lit during the player's turn");

    outcome_exclusive: assert property (@(posedge clock) disable iff (!rst_n) !(won && lost))
        else $error("won and lost both high");

    won_holds: assert property (@(posedge clock) disable iff (!rst_n) won && !start |=> won)
        else $error("won dropped without start");

    lost_holds: assert property (@(posedge clock) disable iff (!rst_n) lost && !start |=> lost)
        else $error("lost dropped without start");

    reset_quiet: assert property (@(posedge clock) $rose(rst_n) |-> !won && !lost && !player_turn)
        else $error("status outputs not low after reset release");

endmodule

bind rhythm_game rhythm_game_asserts rhythm_game_asserts_i (
    .clock       ( clock       ),
    .rst_n       ( rst_n       ),
    .start       ( start       ),
    .leds        ( leds        ),
    .player_turn ( player_turn ),
    .won         ( won         ),
    .lost        ( lost        )
);

//--- testbench/rhythm_game_tb.sv
`timescale 1ns/1ps

module rhythm_game_tb;

    import rhythm_pkg::*;

    localparam int TPU      = 4;
    localparam int ROUNDS   = 3;
    localparam int WAIT_MAX = 400;

    logic                  clock;
    logic                  rst_n;
    logic                  start;
    logic [NOTE_COUNT-1:0] buttons;
    logic [NOTE_COUNT-1:0] leds;
    logic                  player_turn;
    logic                  won;
    logic                  lost;
    round_t                round;

    int    errors;
    int    failed;
    int    mark;
    int    seed;
    int    pick;
    int    cycles;
    bit    timed_out;
    note_t wrong;

    rhythm_game #(.TICKS_PER_UNIT(TPU), .NUM_ROUNDS(ROUNDS)) rhythm_game_i (
        .clock       ( clock       ),
        .rst_n       ( rst_n       ),
        .start       ( start       ),
        .buttons     ( buttons     ),
        .leds        ( leds        ),
        .player_turn ( player_turn ),
        .won         ( won         ),
        .lost        ( lost        ),
        .round       ( round       )
    );

    always #4 clock = ~clock;

    function automatic logic [NOTE_COUNT-1:0] onehot_of(input note_t n);
        logic [NOTE_COUNT-1:0] v;
        v    = '0;
        v[n] = 1'b1;
        return v;
    endfunction

    task automatic check(input bit cond, input string msg);
        if (!timed_out) begin
            assert (cond) else begin
                $display("ERR %0t ns: %s", $time, msg);
                errors++;
            end
        end
    endtask

    task automatic report(input int num, input string name);
        if (errors != mark || timed_out) begin
            failed++;
            $display("test %0d %s: failed", num, name);
        end else begin
            $display("test %0d %s: ok", num, name);
        end
    endtask

    task automatic pulse_start();
        @(posedge clock);
        start <= 1'b1;
        @(posedge clock);
        start <= 1'b0;
    endtask

    // Follows the LEDs note by note and ends in the first cycle of the turn
    task automatic expect_playback(input int r);
        int n;
        n = 0;
        if (!timed_out) begin
            do begin
                @(negedge clock);
                n++;
            end while (leds == '0 && n < WAIT_MAX);
            if (leds == '0) begin
                $display("Timed out waiting for the playback of round %0d to begin", r);
                timed_out = 1'b1;
            end else begin
                check(round == round_t'(r), $sformatf("round is %0d, expected %0d", round, r));
                for (int i = 0; i <= r; i++) begin
                    for (int c = 0; c < MELODY_DURS[i] * TPU; c++) begin
                        if (c > 0 || i > 0) @(negedge clock);
                        check(leds == onehot_of(MELODY_NOTES[i]),
                              $sformatf("leds %h during note %0d of round %0d", leds, i, r));
                    end
                end
                @(negedge clock);
                check(leds == '0 && player_turn, "player_turn not up after playback");
            end
        end
    endtask

    task automatic press_button(input int delay, input note_t note);
        repeat (delay) @(posedge clock);
        buttons <= onehot_of(note);
        repeat (2) @(posedge clock);
        buttons <= '0;
    endtask

    // Presses land in the middle of each window after the press latency
    task automatic play_round(input int r);
        for (int i = 0; i <= r; i++) begin
            press_button(MELODY_DURS[i] * TPU - 2 + (i > 0 ? 1 : 0), MELODY_NOTES[i]);
        end
    endtask

    task automatic wait_for_result(output int n);
        n = 0;
        if (!timed_out) begin
            do begin
                @(negedge clock);
                n++;
            end while (!won && !lost && n < WAIT_MAX);
            if (!won && !lost) begin
                $display("Timed out waiting for the game to be won or lost");
                timed_out = 1'b1;
            end
        end
    endtask

    initial begin
        clock     = 1'b0;
        rst_n     = 1'b0;
        start     = 1'b0;
        buttons   = '0;
        errors    = 0;
        failed    = 0;
        timed_out = 1'b0;
        seed      = 7202;
        repeat (2) @(posedge clock);
        rst_n <= 1'b1;

        mark = errors;
        @(negedge clock);
        check(!won && !lost && !player_turn && leds == '0, "outputs not idle after reset");
        report(1, "reset state");

        mark = errors;
        pulse_start();
        expect_playback(0);
        report(2, "first note playback");

        mark = errors;
        play_round(0);
        expect_playback(1);
        play_round(1);
        expect_playback(2);
        play_round(2);
        wait_for_result(cycles);
        check(won && !lost, "game not won after the last round");
        report(3, "three correct rounds");

        mark  = errors;
        pick  = {$random(seed)} % 11;
        wrong = note_t'((MELODY_NOTES[0] + 1 + pick) % NOTE_COUNT);
        pulse_start();
        expect_playback(0);
        press_button(MELODY_DURS[0] * TPU - 2, wrong);
        wait_for_result(cycles);
        check(lost && !won && round == '0, $sformatf("wrong note %0d did not lose", wrong));
        check(cycles <= TPU, $sformatf("lost %0d cycles after the wrong press", cycles));
        report(4, "wrong note");

        mark = errors;
        pulse_start();
        expect_playback(0);
        wait_for_result(cycles);
        check(lost && !won, "missing press did not lose");
        check(cycles >= (MELODY_DURS[0] + 1) * TPU - 1 && cycles <= (MELODY_DURS[0] + 1) * TPU + 1,
              $sformatf("lost after %0d cycles of silence", cycles));
        report(5, "no press");

        mark = errors;
        pulse_start();
        expect_playback(0);
        press_button(1, MELODY_NOTES[0]);
        wait_for_result(cycles);
        check(lost && !won && round == '0, "early press did not lose");
        check(cycles <= TPU, $sformatf("lost %0d cycles after the early press", cycles));
        report(6, "early press");

        $display("tests run: 6, failed: %0d, errors: %0d", failed, errors);
        if (failed == 0 && errors == 0 && !timed_out) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- flist.f
rtl/rhythm_pkg.sv
rtl/note_checker.sv
rtl/timing_checker.sv
rtl/game_control.sv
rtl/rhythm_game.sv
testbench/rhythm_game_asserts.sv
testbench/rhythm_game_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= rhythm_game_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing -Wall
FAIL_MSG  ?= FAIL: see errors above
PASS_MSG  ?= PASS: all tests

SRCS := $(shell grep -v '^+' $(FLIST))

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
